//--- hw/block_loader.sv
// Z-order quad addressing of the image banks and the 4x4 block buffer
`timescale 1ns/1ps

module block_loader
    import cnn_seq_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  phase_t      phase,
    input  logic [3:0]  block_idx,
    output image_addr_t image_addr,
    input  quad_t       image_rd,
    output block_t      block
);

    logic [1:0] blk_row;
    logic [1:0] blk_col;
    logic [1:0] z_quad;
    logic       cap_en;    // A quad read was issued last cycle
    logic [1:0] cap_quad;  // Which quad of the block it was

    assign blk_row = 2'(block_idx / BLOCKS_PER_ROW);
    assign blk_col = 2'(block_idx % BLOCKS_PER_ROW);

    // UL, UR, LL, LR of the block in phases 0..3
    assign z_quad = phase[1:0];
    assign image_addr = image_addr_t'((blk_row + z_quad[1]) * QUAD_COLS
                                      + blk_col + z_quad[0]);

    always_ff @(posedge clk) begin
        if (reset) begin
            cap_en <= 1'b0;
        end else begin
            cap_en <= (phase < PH_QUADS);
        end
    end

    always_ff @(posedge clk) begin
        cap_quad <= z_quad;
    end

    // Synchronous read data lands one cycle after its address
    always_ff @(posedge clk) begin
        if (cap_en) begin
            block[cap_quad * 4 + 0] <= image_rd.ul;
            block[cap_quad * 4 + 1] <= image_rd.ur;
            block[cap_quad * 4 + 2] <= image_rd.ll;
            block[cap_quad * 4 + 3] <= image_rd.lr;
        end
    end

endmodule

//--- hw/cnn_seq_pkg.sv
// Constants, pixel and quad types, stream word layouts and the result write port
// shared by all units of the convolution operand sequencer
package cnn_seq_pkg;

    // Image geometry, counted in 2x2 quads
    localparam int QUAD_COLS = 4;
    localparam int QUAD_ROWS = 4;
    localparam int BLOCKS_PER_ROW = QUAD_COLS - 1;  // Stride of one quad
    localparam int NUM_BLOCKS = (QUAD_ROWS - 1) * BLOCKS_PER_ROW;

    localparam int NUM_FILTERS = 2;
    localparam int MAC_TAPS = 9;
    localparam int PARAMS_PER_FILTER = MAC_TAPS + 1;  // Bias, then weights

    // Phase map of one block
    localparam int PHASE_COUNT = 17;
    localparam int PH_QUADS = 4;                       // Quad reads in phases 0..3
    localparam int PH_CONV = 4;                        // First weight address
    localparam int PH_HEADER = 6;                      // Header loaded into stream reg
    localparam int PH_CMD = PH_HEADER + MAC_TAPS + 1;  // Command loaded last

    // Post-processing command bytes
    localparam logic [7:0] SSFR_POOL_RELU = 8'hC1;
    localparam logic [7:0] SSFR_CFG = 8'h28;

    typedef logic [7:0] pixel_t;
    typedef logic [3:0] image_addr_t;
    typedef logic [4:0] conv_addr_t;
    typedef logic [3:0] res_addr_t;
    typedef logic [4:0] phase_t;

    // One read of the four image banks
    typedef struct packed {
        pixel_t ul;
        pixel_t ur;
        pixel_t ll;
        pixel_t lr;
    } quad_t;

    // 4x4 block, index quad*4 + bank
    typedef pixel_t [15:0] block_t;

    typedef enum logic [1:0] {
        HEADER,
        TAP,
        CMD
    } word_kind_t;

    // Output word to the MAC unit, decoded by kind
    typedef union packed {
        struct packed {
            pixel_t [3:0] win;  // Same tap of the four windows
            pixel_t       param;
        } taps;
        struct packed {
            pixel_t      count_hi;
            pixel_t      count_lo;
            logic [15:0] pad;
            pixel_t      bias;
        } header;
        struct packed {
            pixel_t      opcode;
            logic [23:0] pad;
            pixel_t      cfg;
        } cmd;
    } stream_word_u;

    typedef struct packed {
        logic         valid;
        word_kind_t   kind;
        stream_word_u word;
    } stream_t;

    typedef struct packed {
        logic [3:0] en;  // One-hot bank enable
        res_addr_t  addr;
        pixel_t     data;
    } res_wr_t;

endpackage

//--- hw/conv_sequencer.sv
// Top level of the convolution operand sequencer
// FSM, counters, block loader, stream emitter and result writer
`timescale 1ns/1ps

module conv_sequencer
    import cnn_seq_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        start,
    output image_addr_t image_addr,
    input  quad_t       image_rd,
    output conv_addr_t  conv_addr,
    input  pixel_t      conv_rd,
    output stream_t     stream,
    input  logic        res_valid,
    input  pixel_t      res_data,
    output res_wr_t     res_wr,
    output logic        busy,
    output logic        done
);

    phase_t     phase;
    logic [3:0] block_idx;
    logic       filter_idx;
    logic       last_job;
    block_t     block;

    layer_fsm u_fsm (
        .clk      (clk),
        .reset    (reset),
        .start    (start),
        .last_job (last_job),
        .busy     (busy),
        .done     (done)
    );

    step_counter u_steps (
        .clk        (clk),
        .reset      (reset),
        .busy       (busy),
        .phase      (phase),
        .block_idx  (block_idx),
        .filter_idx (filter_idx),
        .last_job   (last_job)
    );

    block_loader u_loader (
        .clk        (clk),
        .reset      (reset),
        .phase      (phase),
        .block_idx  (block_idx),
        .image_addr (image_addr),
        .image_rd   (image_rd),
        .block      (block)
    );

    window_emitter u_emitter (
        .clk        (clk),
        .reset      (reset),
        .busy       (busy),
        .phase      (phase),
        .filter_idx (filter_idx),
        .block      (block),
        .conv_addr  (conv_addr),
        .conv_rd    (conv_rd),
        .stream     (stream)
    );

    // Runs whether busy or not
    res_writer u_res (
        .clk       (clk),
        .reset     (reset),
        .start     (start),
        .res_valid (res_valid),
        .res_data  (res_data),
        .res_wr    (res_wr)
    );

endmodule

//--- hw/layer_fsm.sv
// Layer run state machine, IDLE and CONV, with busy level and done pulse
`timescale 1ns/1ps

module layer_fsm (
    input  logic clk,
    input  logic reset,
    input  logic start,
    input  logic last_job,
    output logic busy,
    output logic done
);

    typedef enum logic {
        IDLE,
        CONV
    } state_t;

    state_t state;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= IDLE;
            done  <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                IDLE: begin
                    if (start) begin
                        state <= CONV;
                    end
                end
                CONV: begin
                    // start is ignored here
                    if (last_job) begin
                        state <= IDLE;
                        done  <= 1'b1;  // Lines up with the final command word
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    assign busy = (state == CONV);

endmodule

//--- hw/res_writer.sv
// Round-robin write-back of MAC results into four result banks
`timescale 1ns/1ps

module res_writer
    import cnn_seq_pkg::*;
(
    input  logic    clk,
    input  logic    reset,
    input  logic    start,
    input  logic    res_valid,
    input  pixel_t  res_data,
    output res_wr_t res_wr
);

    logic [1:0] bank_ptr;
    res_addr_t  addr_ptr;
    logic [3:0] wr_en;
    res_addr_t  wr_addr;
    pixel_t     wr_data;

    always_ff @(posedge clk) begin
        if (reset) begin
            bank_ptr <= '0;
            addr_ptr <= '0;
            wr_en    <= '0;
            wr_addr  <= '0;
        end else begin
            wr_en <= '0;  // One-cycle strobe
            if (res_valid) begin
                wr_en    <= 4'b0001 << bank_ptr;
                wr_addr  <= addr_ptr;
                bank_ptr <= bank_ptr + 2'd1;
                if (bank_ptr == 2'd3) begin
                    addr_ptr <= addr_ptr + res_addr_t'(1);  // Next row of four
                end
            end
            if (start) begin
                bank_ptr <= '0;
                addr_ptr <= '0;
            end
        end
    end

    always_ff @(posedge clk) begin
        wr_data <= res_data;
    end

    assign res_wr = '{en: wr_en, addr: wr_addr, data: wr_data};

endmodule

//--- hw/step_counter.sv
// Phase, block and filter counters of one layer run
`timescale 1ns/1ps

module step_counter
    import cnn_seq_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic       busy,
    output phase_t     phase,
    output logic [3:0] block_idx,
    output logic       filter_idx,
    output logic       last_job
);

    logic block_end;
    logic last_block;
    logic last_filter;

    assign block_end   = (phase == phase_t'(PHASE_COUNT - 1));
    assign last_block  = (block_idx == 4'(NUM_BLOCKS - 1));
    assign last_filter = (filter_idx == 1'(NUM_FILTERS - 1));

    always_ff @(posedge clk) begin
        if (reset || !busy) begin
            phase      <= '0;  // Parked at block 0 of filter 0
            block_idx  <= '0;
            filter_idx <= 1'b0;
        end else if (block_end) begin
            phase <= '0;
            if (last_block) begin
                block_idx  <= '0;
                filter_idx <= last_filter ? 1'b0 : filter_idx + 1'b1;
            end else begin
                block_idx <= block_idx + 4'd1;  // Raster order
            end
        end else begin
            phase <= phase + phase_t'(1);
        end
    end

    // Final cycle of the run
    assign last_job = block_end && last_block && last_filter;

endmodule

//--- hw/window_emitter.sv
// Weight addressing and the registered header, tap and command stream
// Word k is loaded in phase 6+k and shows on stream in the next cycle
`timescale 1ns/1ps

module window_emitter
    import cnn_seq_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic       busy,
    input  phase_t     phase,
    input  logic       filter_idx,
    input  block_t     block,
    output conv_addr_t conv_addr,
    input  pixel_t     conv_rd,
    output stream_t    stream
);

    logic [3:0]   param_sel;
    logic [3:0]   tap;
    pixel_t       param_q;  // Weight memory data, one cycle late
    stream_t      nxt;
    logic         valid_q;
    word_kind_t   kind_q;
    stream_word_u word_q;

    // Pixel of window n at tap t, windows overlap by one quad column/row
    function automatic pixel_t window_pixel(block_t blk, int unsigned n, int unsigned t);
        int unsigned r;
        int unsigned c;
        r = n / 2 + t / 3;
        c = n % 2 + t % 3;
        return blk[(r / 2 * 2 + c / 2) * 4 + (r % 2) * 2 + c % 2];
    endfunction

    // Bias then nine weights, phases 4..13
    always_comb begin
        param_sel = '0;
        if (phase >= PH_CONV && phase < PH_CONV + PARAMS_PER_FILTER) begin
            param_sel = 4'(phase - phase_t'(PH_CONV));
        end
        conv_addr = conv_addr_t'(filter_idx) * conv_addr_t'(PARAMS_PER_FILTER)
                    + conv_addr_t'(param_sel);
    end

    always_ff @(posedge clk) begin
        param_q <= conv_rd;
    end

    assign tap = 4'(phase - phase_t'(PH_HEADER + 1));

    always_comb begin
        nxt = '0;
        if (busy) begin
            if (phase == PH_HEADER) begin
                nxt.valid = 1'b1;
                nxt.kind  = HEADER;
                {nxt.word.header.count_hi, nxt.word.header.count_lo} = 16'(MAC_TAPS);
                nxt.word.header.bias = param_q;
            end else if (phase > PH_HEADER && phase < PH_CMD) begin
                nxt.valid = 1'b1;
                nxt.kind  = TAP;
                for (int n = 0; n < 4; n++) begin
                    nxt.word.taps.win[n] = window_pixel(block, n, tap);
                end
                nxt.word.taps.param = param_q;  // Weight tap
            end else if (phase == PH_CMD) begin
                nxt.valid = 1'b1;
                nxt.kind  = CMD;
                nxt.word.cmd.opcode = SSFR_POOL_RELU;
                nxt.word.cmd.cfg    = SSFR_CFG;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= nxt.valid;
        end
    end

    always_ff @(posedge clk) begin
        kind_q <= nxt.kind;
        word_q <= nxt.word;
    end

    assign stream = '{valid: valid_q, kind: kind_q, word: word_q};

endmodule

//--- list.f
hw/cnn_seq_pkg.sv
hw/layer_fsm.sv
hw/step_counter.sv
hw/block_loader.sv
hw/window_emitter.sv
hw/res_writer.sv
hw/conv_sequencer.sv
testbench/tb_conv_sequencer.sv

//--- run.sh
#!/bin/sh
# Build and run the convolution sequencer testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 --top-module tb_conv_sequencer \
    -f list.f --Mdir obj_dir -o sim_tb

./obj_dir/sim_tb | tee sim.log

if grep -q "RESULT: PASS" sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed, see sim.log"
    exit 1
fi

//--- testbench/tb_conv_sequencer.sv
// Testbench for the convolution operand sequencer: memory models, stimulus table,
// expected stream and result write model, compare tasks and watchdog
`timescale 1ns/1ps

module tb_conv_sequencer
    import cnn_seq_pkg::*;
;

    localparam logic [31:0] LCG_SEED = 32'h896b2b67;
    localparam int NUM_ROWS = 3;
    localparam longint WATCHDOG_NS = 2 * NUM_ROWS * NUM_FILTERS * NUM_BLOCKS * PHASE_COUNT * 40;

    typedef struct packed {
        logic [31:0] image_seed;
        logic [31:0] weight_seed;
        logic [31:0] n_res;  // Results written back during the run
    } stim_row_t;

    stim_row_t stim_table [NUM_ROWS] = '{
        '{32'h0000_0001, 32'h0000_00a5, 32'd12},
        '{32'h5a5a_1234, 32'h0f0f_7777, 32'd23},
        '{32'hdead_0042, 32'h1357_9bdf, 32'd6}
    };

    logic        clk;
    logic        reset;
    logic        start;
    image_addr_t image_addr;
    quad_t       image_rd = '0;
    conv_addr_t  conv_addr;
    pixel_t      conv_rd = '0;
    stream_t     stream;
    logic        res_valid;
    pixel_t      res_data;
    res_wr_t     res_wr;
    logic        busy;
    logic        done;

    quad_t        image_mem [QUAD_ROWS * QUAD_COLS];
    pixel_t       conv_mem [32];
    word_kind_t   exp_kind_q [$];
    stream_word_u exp_word_q [$];
    res_wr_t      exp_res;   // Expected res_wr at the next sample point
    logic [1:0]   bank_ptr;
    res_addr_t    addr_ptr;
    logic [31:0]  lcg_state;

    conv_sequencer uut (
        .clk        (clk),
        .reset      (reset),
        .start      (start),
        .image_addr (image_addr),
        .image_rd   (image_rd),
        .conv_addr  (conv_addr),
        .conv_rd    (conv_rd),
        .stream     (stream),
        .res_valid  (res_valid),
        .res_data   (res_data),
        .res_wr     (res_wr),
        .busy       (busy),
        .done       (done)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Synchronous-read image banks and weight memory
    always @(posedge clk) begin
        image_rd <= image_mem[image_addr];
        conv_rd  <= conv_mem[conv_addr];
    end

    task automatic report_failure(string msg);
        $display("%s", msg);
        $display("RESULT: FAIL");
        $fatal(1, "Simulation stopped on the first error");
    endtask

    function automatic logic [31:0] lcg_draw();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // Pixel (y, x) of the 8x8 image, banks hold 2x2 quads
    function automatic pixel_t image_pixel(int y, int x);
        quad_t q;
        q = image_mem[(y / 2) * QUAD_COLS + x / 2];
        case ((y % 2) * 2 + x % 2)
            0: return q.ul;
            1: return q.ur;
            2: return q.ll;
            default: return q.lr;
        endcase
    endfunction

    task automatic fill_memories(stim_row_t row);
        lcg_state = LCG_SEED ^ row.image_seed;
        for (int a = 0; a < QUAD_ROWS * QUAD_COLS; a++) begin
            image_mem[a] = quad_t'(lcg_draw());
        end
        lcg_state = LCG_SEED ^ row.weight_seed;
        for (int a = 0; a < 32; a++) begin
            conv_mem[a] = pixel_t'(lcg_draw() >> 24);
        end
    endtask

    // Whole word sequence of one run, filter 0 first, blocks in raster order
    task automatic build_expected();
        stream_word_u w;
        int br;
        int bc;
        int base;
        exp_kind_q.delete();
        exp_word_q.delete();
        for (int f = 0; f < NUM_FILTERS; f++) begin
            for (int b = 0; b < NUM_BLOCKS; b++) begin
                br = b / BLOCKS_PER_ROW;
                bc = b % BLOCKS_PER_ROW;
                base = f * PARAMS_PER_FILTER;
                w = '0;
                w.header.count_hi = pixel_t'(MAC_TAPS >> 8);
                w.header.count_lo = pixel_t'(MAC_TAPS);
                w.header.bias = conv_mem[base];
                exp_kind_q.push_back(HEADER);
                exp_word_q.push_back(w);
                for (int t = 0; t < MAC_TAPS; t++) begin
                    w = '0;
                    for (int n = 0; n < 4; n++) begin
                        w.taps.win[n] = image_pixel(2 * br + n / 2 + t / 3,
                                                    2 * bc + n % 2 + t % 3);
                    end
                    w.taps.param = conv_mem[base + 1 + t];
                    exp_kind_q.push_back(TAP);
                    exp_word_q.push_back(w);
                end
                w = '0;
                w.cmd.opcode = SSFR_POOL_RELU;
                w.cmd.cfg = SSFR_CFG;
                exp_kind_q.push_back(CMD);
                exp_word_q.push_back(w);
            end
        end
    endtask

    task automatic check_word(word_kind_t got_kind, stream_word_u got,
                              word_kind_t exp_kind, stream_word_u exp);
        if (got_kind !== exp_kind) begin
            report_failure($sformatf("MISMATCH stream.kind got %h exp %h", got_kind, exp_kind));
        end
        if (got !== exp) begin
            report_failure($sformatf("MISMATCH stream.word got %h exp %h", got, exp));
        end
    endtask

    task automatic check_res_wr(res_wr_t got, res_wr_t exp);
        if (got !== exp) begin
            report_failure($sformatf("MISMATCH res_wr got %h exp %h", got, exp));
        end
    endtask

    // Sets up the result strobe for the next edge and what res_wr must show after it
    task automatic drive_result(bit strobe);
        if (strobe) begin
            res_valid = 1'b1;
            res_data = pixel_t'(lcg_draw() >> 16);
            exp_res = '{en: 4'b0001 << bank_ptr, addr: addr_ptr, data: res_data};
            if (bank_ptr == 2'd3) begin
                addr_ptr = addr_ptr + res_addr_t'(1);
            end
            bank_ptr = bank_ptr + 2'd1;
        end else begin
            res_valid = 1'b0;
            exp_res.en = '0;  // Address keeps the last write
            exp_res.data = res_data;
        end
    endtask

    task automatic idle_cycles(int n);
        repeat (n) begin
            @(negedge clk);
            check_res_wr(res_wr, exp_res);
            if (busy || done || stream.valid) begin
                report_failure("busy, done or stream.valid is high while the sequencer is idle");
            end
            drive_result(1'b0);
        end
    endtask

    task automatic run_row(stim_row_t row);
        int unsigned cycle;
        int unsigned sent;
        bit done_seen;
        fill_memories(row);
        build_expected();
        @(negedge clk);
        check_res_wr(res_wr, exp_res);
        start = 1'b1;
        drive_result(1'b0);
        bank_ptr = '0;  // Start restarts both result pointers
        addr_ptr = '0;
        cycle = 0;
        sent = 0;
        done_seen = 1'b0;
        while (!done_seen) begin
            @(negedge clk);
            start = 1'b0;
            check_res_wr(res_wr, exp_res);
            if (stream.valid) begin
                if (exp_kind_q.size() == 0) begin
                    report_failure("stream produced more words than one run should have");
                end
                check_word(stream.kind, stream.word, exp_kind_q.pop_front(),
                           exp_word_q.pop_front());
            end
            if (done) begin
                done_seen = 1'b1;
                if (!(stream.valid && stream.kind == CMD)) begin
                    report_failure("done did not come with the final command word");
                end
                if (exp_kind_q.size() != 0) begin
                    report_failure("done came before all stream words were sent");
                end
                if (busy) begin
                    report_failure("busy was still high in the done cycle");
                end
            end else if (!busy) begin
                report_failure("busy dropped before done");
            end
            if (sent < row.n_res && cycle % 3 == 2) begin
                drive_result(1'b1);
                sent++;
            end else begin
                drive_result(1'b0);
            end
            cycle++;
        end
        idle_cycles(4);  // done is a single pulse, nothing follows it
    endtask

    initial begin
        #(WATCHDOG_NS);
        report_failure("Timeout: the run did not finish within the watchdog limit");
    end

    initial begin
        reset = 1'b1;
        start = 1'b0;
        res_valid = 1'b0;
        res_data = '0;
        exp_res = '0;
        bank_ptr = '0;
        addr_ptr = '0;
        lcg_state = LCG_SEED;
        repeat (4) @(negedge clk);
        reset = 1'b0;
        idle_cycles(6);
        foreach (stim_table[i]) begin
            run_row(stim_table[i]);
        end
        $display("RESULT: PASS");
        $finish;
    end

endmodule
